// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - logic/ctrl_pkg.sv
  - logic/delay_line.sv
  - logic/instr_mem.sv
  - logic/a_mem.sv
  - logic/pc_controller.sv
  - logic/control_path.sv
  - logic/control_unit.sv

  - target: test
    files:
      - verification/control_unit_sva.sv
      - verification/control_unit_tb.sv

# file list for the simulator: sim.f
# testbench top: control_unit_tb
# design top: control_unit

// ==== logic/a_mem.sv ====
`timescale 1ns/1ps

module a_mem
    import ctrl_pkg::*;
(
    input  logic                    clock,
    input  logic                    arst_n,
    input  mem_write_t              write_port,
    input  logic [A_ADDR_WIDTH-1:0] read_addr,
    output a_word_t                 read_data
);

    logic    wren;
    a_word_t mem [A_DEPTH];
    a_word_t read_q;

    // ####################
    // write enable
    // ####################

    assign wren = write_port.wren_other && (write_port.op == OP_AWR);

    // ####################
    // storage
    // ####################

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_port.addr[A_ADDR_WIDTH-1:0]] <= write_port.data;
        end
    end

    always_ff @(posedge clock) begin
        read_q <= mem[read_addr];
    end

    // ####################
    // alignment
    // ####################

    // address comes from the tap stage; the word is needed at operand read.
    delay_line
    #(
        .T      (a_word_t),
        .DEPTH  (TAP_AB_PIPE_DEPTH + AB_READ_PIPE_DEPTH - 1)
    )
    align_pipe
    (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_data    (read_q),
        .out_data   (read_data)
    );

endmodule

// ==== logic/control_path.sv ====
`timescale 1ns/1ps

module control_path
    import ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  mem_write_t write_port,
    input  pc_t        read_addr,
    input  a_word_t    a_read_data,
    output instr_t     instr,
    output pc_t        pc
);

    instr_t i_read_data;
    instr_t i_read_data_ab;
    instr_t ab_instr;
    pc_t    ctrl_pc;

    // ####################
    // fetch
    // ####################

    instr_mem i_mem (
        .clock      (clock),
        .write_port (write_port),
        .read_addr  (read_addr),
        .read_data  (i_read_data)
    );

    // extra stage after the ram, may be retimed into it.
    delay_line #(.T(instr_t), .DEPTH(I_TAP_PIPE_DEPTH)) i_tap_pipe (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_data    (i_read_data),
        .out_data   (instr)
    );

    // ####################
    // operand read
    // ####################

    delay_line #(.T(instr_t), .DEPTH(TAP_AB_PIPE_DEPTH)) tap_ab_pipe (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_data    (instr),
        .out_data   (i_read_data_ab)
    );

    delay_line #(.T(instr_t), .DEPTH(AB_READ_PIPE_DEPTH)) ab_read_pipe (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_data    (i_read_data_ab),
        .out_data   (ab_instr)
    );

    // ####################
    // controller
    // ####################

    pc_controller controller (
        .clock          (clock),
        .arst_n         (arst_n),
        .ab_instr       (ab_instr),
        .a_read_data    (a_read_data),
        .pc             (ctrl_pc)
    );

    delay_line #(.T(pc_t), .DEPTH(PC_PIPE_DEPTH)) pc_pipe (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_data    (ctrl_pc),
        .out_data   (pc)
    );

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps

module control_unit
    import ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  mem_write_t write_port,
    output instr_t     instr,
    output pc_t        pc
);

    a_word_t a_read_data;

    // fetch loop, pc goes straight back as the read address.
    control_path ctrl_path (
        .clock          (clock),
        .arst_n         (arst_n),
        .write_port     (write_port),
        .read_addr      (pc),
        .a_read_data    (a_read_data),
        .instr          (instr),
        .pc             (pc)
    );

    // operand address from the A field.
    a_mem a_memory (
        .clock      (clock),
        .arst_n     (arst_n),
        .write_port (write_port),
        .read_addr  (instr.a),
        .read_data  (a_read_data)
    );

endmodule

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    // ####################
    // widths and sizes
    // ####################

    localparam int INSTR_WIDTH       = 24;
    localparam int OPCODE_WIDTH      = 4;
    localparam int D_OPERAND_WIDTH   = 8;
    localparam int A_OPERAND_WIDTH   = 6;
    localparam int B_OPERAND_WIDTH   = 6;

    localparam int I_ADDR_WIDTH      = 8;
    localparam int I_DEPTH           = 256;

    localparam int A_WORD_WIDTH      = 24;
    localparam int A_ADDR_WIDTH      = 6;
    localparam int A_DEPTH           = 64;

    localparam int THREAD_COUNT      = 8;
    localparam int THREAD_ADDR_WIDTH = 3;
    localparam int THREAD_STRIDE     = 32;

    // stage depths, plus one mem read and one controller cycle, make THREAD_COUNT.
    localparam int PC_PIPE_DEPTH      = 1;
    localparam int I_TAP_PIPE_DEPTH   = 1;
    localparam int TAP_AB_PIPE_DEPTH  = 2;
    localparam int AB_READ_PIPE_DEPTH = 2;

    // ####################
    // types
    // ####################

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_NOP = 4'd0,
        OP_JMP = 4'd1,
        OP_JZ  = 4'd2,
        OP_JNZ = 4'd3,
        OP_IWR = 4'd8,
        OP_AWR = 4'd9
    } opcode_t;

    typedef logic [I_ADDR_WIDTH-1:0] pc_t;
    typedef logic [A_WORD_WIDTH-1:0] a_word_t;

    typedef struct packed {
        opcode_t                    op;
        logic [D_OPERAND_WIDTH-1:0] d;
        logic [A_OPERAND_WIDTH-1:0] a;
        logic [B_OPERAND_WIDTH-1:0] b;
    } instr_t;

    // shared write port into both memories.
    typedef struct packed {
        logic                       wren_other;
        opcode_t                    op;
        logic [D_OPERAND_WIDTH-1:0] addr;
        a_word_t                    data;
    } mem_write_t;

    // start address of each thread.
    localparam pc_t THREAD_BASE [THREAD_COUNT] = '{
        pc_t'(0 * THREAD_STRIDE),
        pc_t'(1 * THREAD_STRIDE),
        pc_t'(2 * THREAD_STRIDE),
        pc_t'(3 * THREAD_STRIDE),
        pc_t'(4 * THREAD_STRIDE),
        pc_t'(5 * THREAD_STRIDE),
        pc_t'(6 * THREAD_STRIDE),
        pc_t'(7 * THREAD_STRIDE)
    };

endpackage

// ==== logic/delay_line.sv ====
`timescale 1ns/1ps

module delay_line
#(
    parameter type T     = logic,
    parameter int  DEPTH = 1
)
(
    input  logic clock,
    input  logic arst_n,
    input  T     in_data,
    output T     out_data
);

    generate
        if (DEPTH == 0) begin : g_bypass
            assign out_data = in_data;
        end else begin : g_chain
            T stage [DEPTH];

            always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage[i] <= T'(0);
                    end
                end else begin
                    stage[0] <= in_data;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            // last stage is the output.
            assign out_data = stage[DEPTH-1];
        end
    endgenerate

endmodule

// ==== logic/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem
    import ctrl_pkg::*;
(
    input  logic       clock,
    input  mem_write_t write_port,
    input  pc_t        read_addr,
    output instr_t     read_data
);

    logic                   wren;
    logic [INSTR_WIDTH-1:0] mem [I_DEPTH];

    // ####################
    // write enable
    // ####################

    // only an instruction write touches this memory.
    assign wren = write_port.wren_other && (write_port.op == OP_IWR);

    // ####################
    // storage
    // ####################

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_port.addr] <= write_port.data[INSTR_WIDTH-1:0];
        end
    end

    // registered read, one cycle.
    always_ff @(posedge clock) begin
        read_data <= instr_t'(mem[read_addr]);
    end

endmodule

// ==== logic/pc_controller.sv ====
`timescale 1ns/1ps

module pc_controller
    import ctrl_pkg::*;
(
    input  logic    clock,
    input  logic    arst_n,
    input  instr_t  ab_instr,
    input  a_word_t a_read_data,
    output pc_t     pc
);

    logic [THREAD_ADDR_WIDTH-1:0] thread;
    logic                         primed;
    pc_t                          pc_store [THREAD_COUNT];

    pc_t     cur_pc;
    pc_t     seq_pc;
    pc_t     branch_pc;
    pc_t     next_pc;
    opcode_t op;
    pc_t     d;
    logic    a_zero;

    // ####################
    // decode
    // ####################

    assign op = ab_instr.op;
    assign d  = pc_t'(ab_instr.d);

    assign a_zero = (a_read_data == '0);

    // ####################
    // next pc
    // ####################

    assign cur_pc = pc_store[thread];
    assign seq_pc = cur_pc + 1'b1;

    always_comb begin
        case (op)
            OP_JMP: begin
                branch_pc = d;
            end
            OP_JZ: begin
                branch_pc = a_zero ? d : seq_pc;
            end
            OP_JNZ: begin
                branch_pc = a_zero ? seq_pc : d;
            end
            default: begin
                branch_pc = seq_pc;
            end
        endcase
    end

    // first rotation replays the base addresses, the pipe holds no real instructions yet.
    assign next_pc = primed ? branch_pc : cur_pc;

    // ####################
    // thread rotation
    // ####################

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            thread <= '0;
            primed <= 1'b0;
        end else begin
            thread <= thread + 1'b1;
            if (thread == THREAD_ADDR_WIDTH'(THREAD_COUNT - 1)) begin
                primed <= 1'b1;
            end
        end
    end

    // ####################
    // pc store
    // ####################

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < THREAD_COUNT; i++) begin
                pc_store[i] <= THREAD_BASE[i];
            end
        end else begin
            pc_store[thread] <= next_pc;
        end
    end

    // issued pc.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// ==== sim.f ====
logic/ctrl_pkg.sv
logic/delay_line.sv
logic/instr_mem.sv
logic/a_mem.sv
logic/pc_controller.sv
logic/control_path.sv
logic/control_unit.sv
verification/control_unit_sva.sv
verification/control_unit_tb.sv

// ==== verification/control_unit_sva.sv ====
`timescale 1ns/1ps

module control_unit_sva
    import ctrl_pkg::*;
(
    input logic                         clock,
    input logic                         arst_n,
    input mem_write_t                   write_port,
    input pc_t                          pc,
    input logic [THREAD_ADDR_WIDTH-1:0] thread,
    input logic                         i_wren,
    input logic [INSTR_WIDTH-1:0]       i_words [I_DEPTH]
);

    // ####################
    // controller
    // ####################

    // one step per cycle and a wrap after the last thread.
    a_thread_steps: assert property (
        @(posedge clock) disable iff (!arst_n)
            arst_n |=> thread == THREAD_ADDR_WIDTH'($past(thread) + 1)
    ) else $error("thread counter did not advance by one");

    a_pc_known: assert property (
        @(posedge clock) disable iff (!arst_n)
            !$isunknown(pc)
    ) else $error("pc is unknown out of reset");

    // ####################
    // write port
    // ####################

    // an enabled instruction write holds at its address a cycle later.
    a_iwr_lands: assert property (
        @(posedge clock)
            i_wren |=> i_words[$past(write_port.addr)] ==
                       $past(write_port.data[INSTR_WIDTH-1:0])
    ) else $error("instruction memory write did not take effect");

endmodule

bind control_path control_unit_sva sva0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .write_port (write_port),
    .pc         (pc),
    .thread     (controller.thread),
    .i_wren     (i_mem.wren),
    .i_words    (i_mem.mem)
);

// ==== verification/control_unit_tb.sv ====
`timescale 1ns/1ps

module control_unit_tb
    import ctrl_pkg::*;
();

    logic       clock;
    logic       arst_n;
    mem_write_t write_port;
    instr_t     instr;
    pc_t        pc;

    integer  seed;
    int      mismatch_count;
    int      timeout_count;
    int      check_count;
    int      cycle_k;
    bit      running;
    instr_t  i_mirror [I_DEPTH];
    a_word_t a_mirror [A_DEPTH];
    pc_t     model_pc [THREAD_COUNT];
    instr_t  model_instr [THREAD_COUNT];
    instr_t  instr_q [$];

    control_unit dut0 (
        .clock      (clock),
        .arst_n     (arst_n),
        .write_port (write_port),
        .instr      (instr),
        .pc         (pc)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ####################
    // helpers
    // ####################

    function automatic instr_t make_instr(input opcode_t op, input pc_t d, input int a);
        return instr_t'{op: op, d: d, a: a[A_OPERAND_WIDTH-1:0], b: '0};
    endfunction

    function automatic a_word_t random_nonzero();
        a_word_t value;
        value = a_word_t'($random(seed));
        if (value == '0) begin
            value = a_word_t'(1);
        end
        return value;
    endfunction

    // expected next pc of a thread.
    function automatic pc_t next_pc(input pc_t cur, input instr_t ins, input a_word_t a_word);
        pc_t target;
        pc_t step;
        target = pc_t'(ins.d);
        step   = pc_t'(cur + 1);
        if (ins.op == OP_JMP) begin
            return target;
        end else if (ins.op == OP_JZ) begin
            return (a_word == '0) ? target : step;
        end else if (ins.op == OP_JNZ) begin
            return (a_word != '0) ? target : step;
        end
        return step;
    endfunction

    // one strobe on the shared port; mirrors follow the opcode qualification.
    task automatic drive_write(input logic wren, input opcode_t op, input pc_t addr,
                               input a_word_t data);
        @(posedge clock);
        write_port <= '{wren_other: wren, op: op, addr: addr, data: data};
        if (wren && op == OP_IWR) begin
            i_mirror[addr] = instr_t'(data);
        end
        if (wren && op == OP_AWR) begin
            a_mirror[addr[A_ADDR_WIDTH-1:0]] = data;
        end
    endtask

    task automatic idle_port();
        @(posedge clock);
        write_port <= '0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: expected %0h, actual %0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic wait_for_pc(input pc_t target, input int limit, output bit found);
        found = 1'b0;
        for (int i = 0; i < limit && !found; i++) begin
            @(negedge clock);
            if (pc === target) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            timeout_count++;
            $display("timeout: pc did not reach %0d within %0d cycles", target, limit);
        end
    endtask

    task automatic load_memories();
        pc_t base;
        int  len;
        drive_write(1'b1, OP_AWR, 8'd0, '0);
        drive_write(1'b1, OP_AWR, 8'd1, '0);
        drive_write(1'b1, OP_AWR, 8'd2, random_nonzero());
        drive_write(1'b1, OP_AWR, 8'd3, random_nonzero());
        for (int t = 0; t < THREAD_COUNT; t++) begin
            base = pc_t'(t * THREAD_STRIDE);
            if (t < 2 || t > 5) begin
                // straight nops, then home.
                len = (t == 0) ? 6 : ((t == 1) ? 1 : 3);
                for (int i = 0; i < len; i++) begin
                    drive_write(1'b1, OP_IWR, base + i, make_instr(OP_NOP, 0, 0));
                end
                drive_write(1'b1, OP_IWR, base + len, make_instr(OP_JMP, base, 0));
            end else begin
                // zero word at A[1], nonzero at A[2] and A[3].
                drive_write(1'b1, OP_IWR, base, make_instr((t < 4) ? OP_JZ : OP_JNZ,
                            base + 4, (t == 2 || t == 5) ? 1 : t - 1));
                drive_write(1'b1, OP_IWR, base + 1, make_instr(OP_JMP, base, 0));
                drive_write(1'b1, OP_IWR, base + 4, make_instr(OP_JMP, base, 0));
            end
        end
        drive_write(1'b1, OP_IWR, 8'd234, make_instr(OP_JMP, 8'd224, 0));
        idle_port();
    endtask

    // ####################
    // compare
    // ####################

    always @(negedge clock) begin : compare_outputs
        int     t;
        pc_t    exp_pc;
        instr_t exp_instr;
        if (arst_n && running) begin
            exp_pc = '0;
            if (cycle_k >= 1) begin
                t = (cycle_k - 1) % THREAD_COUNT;
                if (cycle_k <= THREAD_COUNT) begin
                    exp_pc = pc_t'(t * THREAD_STRIDE);
                end else begin
                    exp_pc = next_pc(model_pc[t], model_instr[t],
                                     a_mirror[model_instr[t].a]);
                end
                model_pc[t]    = exp_pc;
                model_instr[t] = i_mirror[exp_pc];
            end
            exp_instr = instr_q.pop_front();
            instr_q.push_back(i_mirror[exp_pc]);
            check_value($sformatf("pc cycle %0d", cycle_k), exp_pc, pc);
            check_value($sformatf("instr cycle %0d", cycle_k), exp_instr, instr);
            cycle_k++;
        end
    end

    // ####################
    // stimulus
    // ####################

    initial begin : stimulus
        bit found;
        seed           = 27;
        arst_n         = 1'b0;
        write_port     = '0;
        running        = 1'b0;
        cycle_k        = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        check_count    = 0;
        load_memories();
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;
        @(posedge clock);
        instr_q = {i_mirror[0], i_mirror[0]};
        running = 1'b1;
        // unqualified strobes aimed at thread 6.
        wait_for_pc(8'd192, 40, found);
        if (found) begin
            drive_write(1'b0, OP_IWR, 8'd193, random_nonzero());
            drive_write(1'b1, OP_NOP, 8'd194, random_nonzero());
            drive_write(1'b1, OP_JMP, 8'd193, random_nonzero());
            drive_write(1'b0, OP_AWR, 8'd1, random_nonzero());
            idle_port();
            repeat (48) @(posedge clock);
            wait_for_pc(8'd224, 64, found);
        end
        if (found) begin
            // thread 7 sits at its base, so base+2 is two rotations away.
            drive_write(1'b1, OP_IWR, 8'd226, make_instr(OP_JZ, 8'd234, 1));
            idle_port();
            repeat (120) @(posedge clock);
        end
        running = 1'b0;
        $display("errors: %0d mismatches, %0d timeouts in %0d checks",
                 mismatch_count, timeout_count, check_count);
        if (mismatch_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
